// ==== Bender.yml ====
package:
  name: rv64_core_pipeline

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/core_pkg.sv
      - verilog/fetch_fsm.sv
      - verilog/pc_counter.sv
      - verilog/decoder.sv
      - verilog/regfile.sv
      - verilog/alu.sv
      - verilog/core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/imem_model.sv
      - test/tb_core.sv

// ==== include/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Sizes shared by the pipeline and its testbench

`define CORE_XLEN 64 // Integer register and datapath width

`define CORE_NREGS 32 // Architectural integer registers

`define CORE_RESET_PC 64'h0000_0000_8000_0000 // First fetch address

`endif

// ==== tb.f ====
+incdir+include
verilog/core_pkg.sv
verilog/fetch_fsm.sv
verilog/pc_counter.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/core.sv
test/imem_model.sv
test/tb_core.sv

// ==== test/imem_model.sv ====
`timescale 1ns/1ps

`include "core_config.svh"

module imem_model #(
	parameter int DEPTH = 256
) (
	input  logic                  clk,
	input  logic                  zero_latency,
	input  logic                  ireq_valid,
	input  logic [`CORE_XLEN-1:0] ireq_addr,
	output logic                  iresp_data_ok,
	output logic [31:0]           iresp_data
);

	logic [31:0] prog [DEPTH];
	logic        busy;
	int unsigned wait_cnt;

	function automatic logic [31:0] read_word(input logic [`CORE_XLEN-1:0] addr);
		logic [`CORE_XLEN-1:0] idx;
		logic [31:0]           word;
		idx = (addr - `CORE_RESET_PC) >> 2;
		if (idx < DEPTH) begin
			word = prog[idx];
		end else begin
			word = {25'(idx ^ (idx >> 25) ^ (idx >> 50)), 7'h7f}; // Unsupported opcode past the array
		end
		return word;
	endfunction

	initial begin
		busy          = 1'b0;
		wait_cnt      = 0;
		iresp_data_ok = 1'b0;
		iresp_data    = '0;
	end

	// One request at a time; the core drops ireq_valid for a cycle after each response
	always @(posedge clk) begin
		#1;
		iresp_data_ok = 1'b0;
		if (ireq_valid) begin
			if (!busy) begin
				busy     = 1'b1;
				wait_cnt = zero_latency ? 0 : $urandom_range(3); // Extra cycles
			end
			if (wait_cnt == 0) begin
				iresp_data_ok = 1'b1;
				iresp_data    = read_word(ireq_addr);
				busy          = 1'b0;
			end else begin
				wait_cnt--;
			end
		end
	end

endmodule

// ==== test/tb_core.sv ====
`timescale 1ns/1ps

`include "core_config.svh"

module tb_core;

	localparam int DEPTH    = 256;
	localparam int RAND_LEN = 80;

	logic                  clk;
	logic                  reset;
	logic                  ireq_valid;
	logic [`CORE_XLEN-1:0] ireq_addr;
	logic                  iresp_data_ok;
	logic [31:0]           iresp_data;
	logic                  commit_valid;
	logic [`CORE_XLEN-1:0] commit_pc;
	logic [31:0]           commit_instr;
	logic                  commit_wen;
	core_pkg::reg_addr_t   commit_wdest;
	logic [`CORE_XLEN-1:0] commit_wdata;
	logic                  zero_latency;

	logic [`CORE_XLEN-1:0] golden [`CORE_NREGS];
	logic [31:0]           prog_q [$];
	string                 test_name;
	logic                  active;
	int                    ncommit;
	int                    nchecks;
	int                    errors;
	logic                  timed_out;

	core dut (
		.clk, .reset, .ireq_valid, .ireq_addr, .iresp_data_ok, .iresp_data,
		.commit_valid, .commit_pc, .commit_instr, .commit_wen, .commit_wdest, .commit_wdata
	);

	imem_model #(.DEPTH(DEPTH)) u_imem (
		.clk, .zero_latency, .ireq_valid, .ireq_addr, .iresp_data_ok, .iresp_data
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	// Executes one instruction on the golden registers
	function automatic void ref_step(input logic [31:0] instr, output logic wen,
			output logic [4:0] wdest, output logic [`CORE_XLEN-1:0] wdata);
		logic [`CORE_XLEN-1:0] a;
		logic [`CORE_XLEN-1:0] b;
		logic [`CORE_XLEN-1:0] imm_i;
		logic [`CORE_XLEN-1:0] imm_u;
		logic                  known;
		a     = golden[instr[19:15]];
		b     = golden[instr[24:20]];
		imm_i = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
		imm_u = {{(`CORE_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
		known = 1'b1;
		wdata = '0;
		case (instr[6:0])
			7'b0110111: wdata = imm_u;
			7'b0010011: begin
				case (instr[14:12])
					3'b000: wdata = a + imm_i;
					3'b100: wdata = a ^ imm_i;
					3'b110: wdata = a | imm_i;
					3'b111: wdata = a & imm_i;
					default: known = 1'b0;
				endcase
			end
			7'b0110011: begin
				case ({instr[31:25], instr[14:12]})
					10'b0000000_000: wdata = a + b;
					10'b0100000_000: wdata = a - b;
					10'b0000000_100: wdata = a ^ b;
					10'b0000000_110: wdata = a | b;
					10'b0000000_111: wdata = a & b;
					default: known = 1'b0;
				endcase
			end
			default: known = 1'b0;
		endcase
		wdest = instr[11:7];
		wen   = known && (wdest != 5'd0);
		if (wen) begin
			golden[wdest] = wdata;
		end
	endfunction

	task automatic compare_field(input string field, input logic [`CORE_XLEN-1:0] expected,
			input logic [`CORE_XLEN-1:0] actual);
		nchecks++;
		assert (actual === expected) else begin
			errors++;
			$display("mismatch %s %s: expected %h, actual %h",
				test_name, field, expected, actual);
		end
	endtask

	always @(negedge clk) begin
		logic                  exp_wen;
		logic [4:0]            exp_wdest;
		logic [`CORE_XLEN-1:0] exp_wdata;
		logic [`CORE_XLEN-1:0] exp_pc;
		if (active && commit_valid && (ncommit < prog_q.size())) begin
			exp_pc = `CORE_RESET_PC + (ncommit * 4); // Program order, no gaps
			ref_step(prog_q[ncommit], exp_wen, exp_wdest, exp_wdata);
			compare_field($sformatf("commit %0d pc", ncommit), exp_pc, commit_pc);
			compare_field($sformatf("commit %0d instr", ncommit), prog_q[ncommit], commit_instr);
			compare_field($sformatf("commit %0d wen", ncommit), exp_wen, commit_wen);
			compare_field($sformatf("commit %0d wdest", ncommit), exp_wdest, commit_wdest);
			if (exp_wen) begin
				compare_field($sformatf("commit %0d wdata", ncommit), exp_wdata, commit_wdata);
			end
			ncommit++;
		end
	end

	task automatic build_directed();
		prog_q.delete();
		prog_q.push_back(enc_u(20'h12345, 5'd1)); // Positive lui
		prog_q.push_back(enc_u(20'hfedcb, 5'd2)); // Negative lui
		prog_q.push_back(enc_i(12'h7ff, 5'd0, 3'b000, 5'd3));
		prog_q.push_back(enc_i(12'hfff, 5'd0, 3'b000, 5'd4));
		prog_q.push_back(enc_i(12'hffb, 5'd1, 3'b000, 5'd5));
		prog_q.push_back(enc_i(12'h5a5, 5'd2, 3'b100, 5'd6));
		prog_q.push_back(enc_i(12'h800, 5'd3, 3'b110, 5'd7));
		prog_q.push_back(enc_i(12'h0f0, 5'd2, 3'b111, 5'd8));
		prog_q.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd9));
		prog_q.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd10));
		prog_q.push_back(enc_r(7'h00, 5'd4, 5'd2, 3'b100, 5'd11));
		prog_q.push_back(enc_r(7'h00, 5'd6, 5'd5, 3'b110, 5'd12));
		prog_q.push_back(enc_r(7'h00, 5'd4, 5'd2, 3'b111, 5'd13));
		prog_q.push_back(enc_i(12'h005, 5'd1, 3'b000, 5'd0)); // Write to x0 is dropped
		prog_q.push_back(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd14));
		prog_q.push_back(32'h0000_0073); // ecall
		prog_q.push_back({20'habcde, 5'd3, 7'b0001011}); // Custom opcode aimed at x3
		prog_q.push_back(enc_i(12'h002, 5'd1, 3'b001, 5'd1)); // slli
		prog_q.push_back(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd15));
		prog_q.push_back(enc_r(7'h00, 5'd0, 5'd3, 3'b000, 5'd16));
		prog_q.push_back(enc_r(7'h20, 5'd14, 5'd2, 3'b000, 5'd2));
	endtask

	task automatic build_forward();
		prog_q.delete();
		prog_q.push_back(enc_i(12'h007, 5'd0, 3'b000, 5'd1));
		prog_q.push_back(enc_i(12'h001, 5'd1, 3'b000, 5'd2)); // Distance one
		prog_q.push_back(enc_i(12'h002, 5'd1, 3'b000, 5'd3)); // Distance two
		prog_q.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4)); // Distance three
		prog_q.push_back(enc_r(7'h20, 5'd3, 5'd4, 3'b000, 5'd5));
		prog_q.push_back(enc_r(7'h00, 5'd4, 5'd5, 3'b100, 5'd6));
		prog_q.push_back(enc_r(7'h00, 5'd1, 5'd6, 3'b110, 5'd7));
		prog_q.push_back(enc_r(7'h00, 5'd7, 5'd7, 3'b111, 5'd8));
		prog_q.push_back(enc_u(20'h80000, 5'd9));
		prog_q.push_back(enc_i(12'hfff, 5'd9, 3'b000, 5'd9));
		prog_q.push_back(enc_i(12'h001, 5'd9, 3'b000, 5'd9));
		prog_q.push_back(enc_i(12'h123, 5'd9, 3'b100, 5'd0)); // Result must not forward
		prog_q.push_back(enc_r(7'h00, 5'd9, 5'd0, 3'b000, 5'd10));
		prog_q.push_back(enc_r(7'h00, 5'd0, 5'd10, 3'b110, 5'd11));
	endtask

	// Few registers, so dependencies are dense
	task automatic build_random();
		logic [31:0] word;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		prog_q.delete();
		for (int n = 0; n < RAND_LEN; n++) begin
			rd  = 5'($urandom_range(7));
			rs1 = 5'($urandom_range(7));
			rs2 = 5'($urandom_range(7));
			case ($urandom_range(11))
				0: word = enc_u(20'($urandom), rd);
				1: word = enc_i(12'($urandom), rs1, 3'b000, rd);
				2: word = enc_i(12'($urandom), rs1, 3'b100, rd);
				3: word = enc_i(12'($urandom), rs1, 3'b110, rd);
				4: word = enc_i(12'($urandom), rs1, 3'b111, rd);
				5: word = enc_r(7'h00, rs2, rs1, 3'b000, rd);
				6: word = enc_r(7'h20, rs2, rs1, 3'b000, rd);
				7: word = enc_r(7'h00, rs2, rs1, 3'b100, rd);
				8: word = enc_r(7'h00, rs2, rs1, 3'b110, rd);
				9: word = enc_r(7'h00, rs2, rs1, 3'b111, rd);
				10: word = enc_i(12'($urandom), rs1, 3'b001, rd);
				default: word = {25'($urandom), 7'b1110011};
			endcase
			prog_q.push_back(word);
		end
	endtask

	task automatic run_test(input string name, input logic zero_lat);
		int limit;
		int cycles;
		@(negedge clk);
		zero_latency = zero_lat;
		@(posedge clk);
		#1;
		reset     = 1'b1;
		test_name = name;
		ncommit   = 0;
		for (int i = 0; i < `CORE_NREGS; i++) begin
			golden[i] = '0;
		end
		for (int i = 0; i < DEPTH; i++) begin
			u_imem.prog[i] = {i[24:0], 7'h7f};
		end
		for (int i = 0; i < prog_q.size(); i++) begin
			u_imem.prog[i] = prog_q[i];
		end
		repeat (2) @(posedge clk);
		#1;
		reset  = 1'b0;
		active = 1'b1;
		@(negedge clk);
		compare_field("first ireq_valid", 1, ireq_valid);
		compare_field("first request address", `CORE_RESET_PC, ireq_addr);
		limit  = prog_q.size() * 8 + 100;
		cycles = 0;
		while ((ncommit < prog_q.size()) && (cycles < limit)) begin
			@(posedge clk);
			cycles++;
		end
		active = 1'b0; // Fill words fetched past the program are not checked
		nchecks++;
		assert (ncommit == prog_q.size()) else begin
			errors++;
			timed_out = 1'b1;
			$display("timeout in %s: %0d of %0d instructions committed after %0d cycles",
				name, ncommit, prog_q.size(), cycles);
		end
	endtask

	initial begin
		void'($urandom(97984));
		clk          = 1'b0;
		reset        = 1'b1;
		zero_latency = 1'b0;
		active       = 1'b0;
		ncommit      = 0;
		nchecks      = 0;
		errors       = 0;
		timed_out    = 1'b0;
		test_name    = "";
		build_directed();
		run_test("directed", 1'b0);
		if (!timed_out) begin
			build_forward();
			run_test("forward", 1'b1);
		end
		if (!timed_out) begin
			build_random();
			run_test("random", 1'b0);
		end
		$display("checks %0d, errors %0d", nchecks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

`include "core_config.svh"

module alu (
	input  core_pkg::alu_op_e     op,
	input  logic [`CORE_XLEN-1:0] a,
	input  logic [`CORE_XLEN-1:0] b,
	output logic [`CORE_XLEN-1:0] y
);

	always_comb begin
		case (op)
			core_pkg::alu_add: begin
				y = a + b;
			end
			core_pkg::alu_sub: begin
				y = a - b;
			end
			core_pkg::alu_xor: begin
				y = a ^ b;
			end
			core_pkg::alu_or: begin
				y = a | b;
			end
			core_pkg::alu_and: begin
				y = a & b;
			end
			core_pkg::alu_pass_b: begin
				y = b; // lui
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

// ==== verilog/core.sv ====
`timescale 1ns/1ps

`include "core_config.svh"

module core (
	input  logic                  clk,
	input  logic                  reset,
	output logic                  ireq_valid,
	output logic [`CORE_XLEN-1:0] ireq_addr,
	input  logic                  iresp_data_ok,
	input  logic [31:0]           iresp_data,
	output logic                  commit_valid,
	output logic [`CORE_XLEN-1:0] commit_pc,
	output logic [31:0]           commit_instr,
	output logic                  commit_wen,
	output core_pkg::reg_addr_t   commit_wdest,
	output logic [`CORE_XLEN-1:0] commit_wdata
);

	logic                  accept;
	logic [`CORE_XLEN-1:0] pc;

	// Fetch register
	logic                  f_valid;
	logic [`CORE_XLEN-1:0] f_pc;
	core_pkg::instr_u      f_instr;

	// Decoder and register file outputs
	core_pkg::reg_addr_t   dec_rs1;
	core_pkg::reg_addr_t   dec_rs2;
	core_pkg::reg_addr_t   dec_rd;
	core_pkg::alu_op_e     dec_alu_op;
	logic                  dec_use_imm;
	logic [`CORE_XLEN-1:0] dec_imm;
	logic                  dec_reg_write;
	logic [`CORE_XLEN-1:0] rf_rd1;
	logic [`CORE_XLEN-1:0] rf_rd2;
	logic [`CORE_XLEN-1:0] fwd_rs1_val;
	logic [`CORE_XLEN-1:0] fwd_rs2_val;

	// Decode register
	logic                  d_valid;
	logic [`CORE_XLEN-1:0] d_pc;
	logic [31:0]           d_instr;
	core_pkg::reg_addr_t   d_rd;
	core_pkg::alu_op_e     d_alu_op;
	logic                  d_use_imm;
	logic [`CORE_XLEN-1:0] d_imm;
	logic                  d_reg_write;
	logic [`CORE_XLEN-1:0] d_rs1_val;
	logic [`CORE_XLEN-1:0] d_rs2_val;

	logic [`CORE_XLEN-1:0] alu_y;

	// Execute and writeback registers
	logic                  e_valid;
	logic [`CORE_XLEN-1:0] e_pc;
	logic [31:0]           e_instr;
	core_pkg::reg_addr_t   e_rd;
	logic                  e_reg_write;
	logic [`CORE_XLEN-1:0] e_result;
	logic                  w_valid;
	logic [`CORE_XLEN-1:0] w_pc;
	logic [31:0]           w_instr;
	core_pkg::reg_addr_t   w_rd;
	logic                  w_reg_write;
	logic [`CORE_XLEN-1:0] w_result;

	fetch_fsm u_fetch_fsm (.clk, .reset, .iresp_data_ok, .ireq_valid, .accept);

	pc_counter u_pc_counter (.clk, .reset, .accept, .pc);

	assign ireq_addr = pc;

	decoder u_decoder (
		.instr     (f_instr),
		.rs1       (dec_rs1),
		.rs2       (dec_rs2),
		.rd        (dec_rd),
		.alu_op    (dec_alu_op),
		.use_imm   (dec_use_imm),
		.imm       (dec_imm),
		.reg_write (dec_reg_write)
	);

	regfile u_regfile (
		.clk, .reset,
		.ra1 (dec_rs1),
		.ra2 (dec_rs2),
		.rd1 (rf_rd1),
		.rd2 (rf_rd2),
		.wa  (w_rd),
		.wen (w_valid && w_reg_write),
		.wd  (w_result)
	);

	// Decode operands, newest producer first
	always_comb begin
		if (e_valid && e_reg_write && (e_rd == dec_rs1) && (dec_rs1 != '0)) begin
			fwd_rs1_val = e_result;
		end else if (w_valid && w_reg_write && (w_rd == dec_rs1) && (dec_rs1 != '0)) begin
			fwd_rs1_val = w_result;
		end else begin
			fwd_rs1_val = rf_rd1;
		end
		if (e_valid && e_reg_write && (e_rd == dec_rs2) && (dec_rs2 != '0)) begin
			fwd_rs2_val = e_result;
		end else if (w_valid && w_reg_write && (w_rd == dec_rs2) && (dec_rs2 != '0)) begin
			fwd_rs2_val = w_result;
		end else begin
			fwd_rs2_val = rf_rd2;
		end
	end

	// Valid bits; a fetch without accept becomes a bubble
	always_ff @(posedge clk) begin
		if (reset) begin
			f_valid <= 1'b0;
			d_valid <= 1'b0;
			e_valid <= 1'b0;
			w_valid <= 1'b0;
		end else begin
			f_valid <= accept;
			d_valid <= f_valid;
			e_valid <= d_valid;
			w_valid <= e_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			f_pc    <= pc;
			f_instr <= iresp_data;
		end
		d_pc        <= f_pc;
		d_instr     <= f_instr;
		d_rd        <= dec_rd;
		d_alu_op    <= dec_alu_op;
		d_use_imm   <= dec_use_imm;
		d_imm       <= dec_imm;
		d_reg_write <= dec_reg_write;
		d_rs1_val   <= fwd_rs1_val;
		d_rs2_val   <= fwd_rs2_val;
		e_pc        <= d_pc;
		e_instr     <= d_instr;
		e_rd        <= d_rd;
		e_reg_write <= d_reg_write;
		e_result    <= alu_y;
		w_pc        <= e_pc;
		w_instr     <= e_instr;
		w_rd        <= e_rd;
		w_reg_write <= e_reg_write;
		w_result    <= e_result;
	end

	alu u_alu (
		.op (d_alu_op),
		.a  (d_rs1_val),
		.b  (d_use_imm ? d_imm : d_rs2_val),
		.y  (alu_y)
	);

	assign commit_valid = w_valid;
	assign commit_pc    = w_pc;
	assign commit_instr = w_instr;
	assign commit_wen   = w_valid && w_reg_write;
	assign commit_wdest = w_rd;
	assign commit_wdata = w_result;

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

	typedef logic [4:0] reg_addr_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_xor,
		alu_or,
		alu_and,
		alu_pass_b // Immediate straight through, used by lui
	} alu_op_e;

	// Register-register format
	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} instr_r_t;

	// Register-immediate format
	typedef struct packed {
		logic [11:0] imm12;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} instr_i_t;

	// Upper-immediate format
	typedef struct packed {
		logic [19:0] imm20;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} instr_u_t;

	// One instruction word, read through the view its opcode selects
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
		instr_u_t u;
	} instr_u;

endpackage

// ==== verilog/decoder.sv ====
`timescale 1ns/1ps

`include "core_config.svh"

module decoder (
	input  core_pkg::instr_u      instr,
	output core_pkg::reg_addr_t   rs1,
	output core_pkg::reg_addr_t   rs2,
	output core_pkg::reg_addr_t   rd,
	output core_pkg::alu_op_e     alu_op,
	output logic                  use_imm,
	output logic [`CORE_XLEN-1:0] imm,
	output logic                  reg_write
);

	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;

	logic supported;

	always_comb begin
		rs1       = '0;
		rs2       = '0;
		rd        = instr.u.rd; // Same place in every view
		alu_op    = core_pkg::alu_add;
		use_imm   = 1'b0;
		imm       = '0;
		supported = 1'b0;
		case (instr.u.opcode)
			opc_lui: begin
				alu_op    = core_pkg::alu_pass_b;
				use_imm   = 1'b1;
				imm       = {{(`CORE_XLEN-32){instr.u.imm20[19]}}, instr.u.imm20, 12'b0};
				supported = 1'b1;
			end
			opc_op_imm: begin
				rs1       = instr.i.rs1;
				use_imm   = 1'b1;
				imm       = {{(`CORE_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
				supported = 1'b1;
				case (instr.i.funct3)
					3'b000: alu_op = core_pkg::alu_add;
					3'b100: alu_op = core_pkg::alu_xor;
					3'b110: alu_op = core_pkg::alu_or;
					3'b111: alu_op = core_pkg::alu_and;
					default: supported = 1'b0; // Shifts and compares not implemented
				endcase
			end
			opc_op: begin
				rs1       = instr.r.rs1;
				rs2       = instr.r.rs2;
				supported = 1'b1;
				case ({instr.r.funct7, instr.r.funct3})
					{7'b0000000, 3'b000}: alu_op = core_pkg::alu_add;
					{7'b0100000, 3'b000}: alu_op = core_pkg::alu_sub;
					{7'b0000000, 3'b100}: alu_op = core_pkg::alu_xor;
					{7'b0000000, 3'b110}: alu_op = core_pkg::alu_or;
					{7'b0000000, 3'b111}: alu_op = core_pkg::alu_and;
					default: supported = 1'b0;
				endcase
			end
			default: begin
				supported = 1'b0; // Retires without a write
			end
		endcase
	end

	assign reg_write = supported && (rd != '0);

endmodule

// ==== verilog/fetch_fsm.sv ====
`timescale 1ns/1ps

module fetch_fsm (
	input  logic clk,
	input  logic reset,
	input  logic iresp_data_ok,
	output logic ireq_valid,
	output logic accept
);

	localparam logic st_request = 1'b0;
	localparam logic st_gap     = 1'b1;

	logic state;
	logic state_nxt;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_request;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_request: begin
				if (iresp_data_ok) begin
					state_nxt = st_gap; // Request done at this edge
				end
			end
			st_gap: begin
				state_nxt = st_request;
			end
			default: begin
				state_nxt = st_request;
			end
		endcase
	end

	// Level request, low for the single gap cycle
	assign ireq_valid = (state == st_request);

	assign accept = (state == st_request) && iresp_data_ok; // One-cycle pulse

endmodule

// ==== verilog/pc_counter.sv ====
`timescale 1ns/1ps

`include "core_config.svh"

module pc_counter (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  accept,
	output logic [`CORE_XLEN-1:0] pc
);

	logic [`CORE_XLEN-1:0] pc_plus4;

	assign pc_plus4 = pc + `CORE_XLEN'(4);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `CORE_RESET_PC;
		end else if (accept) begin
			pc <= pc_plus4; // Next sequential word
		end
	end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

`include "core_config.svh"

module regfile (
	input  logic                  clk,
	input  logic                  reset,
	input  core_pkg::reg_addr_t   ra1,
	input  core_pkg::reg_addr_t   ra2,
	output logic [`CORE_XLEN-1:0] rd1,
	output logic [`CORE_XLEN-1:0] rd2,
	input  core_pkg::reg_addr_t   wa,
	input  logic                  wen,
	input  logic [`CORE_XLEN-1:0] wd
);

	logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rd1 = (ra1 == '0) ? '0 : ((wen && (wa == ra1)) ? wd : regs[ra1]);
	assign rd2 = (ra2 == '0) ? '0 : ((wen && (wa == ra2)) ? wd : regs[ra2]);

endmodule
